// ==== design/slm_ctrl_pkg.sv ====
package slm_ctrl_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // link and frame sizes
  ////////////////////////////////////////////////////////////////////////////
  localparam int BYTE_W            = 8;
  localparam int CLKS_PER_BIT      = 20;
  localparam int SPI_FRAME_W       = 16;
  localparam int SPI_HALF_PERIOD   = 4;
  localparam int RESET_HOLD_CYCLES = 10;
  localparam int REPLY_DEPTH       = 4;

  // uart bit timing
  localparam int                BAUD_W    = $clog2(CLKS_PER_BIT);
  localparam logic [BAUD_W-1:0] BAUD_LAST = BAUD_W'(CLKS_PER_BIT - 1);
  localparam logic [BAUD_W-1:0] BAUD_MID  = BAUD_W'((CLKS_PER_BIT - 1) / 2);
  // bit index over start, data and stop
  localparam int               BIT_W        = $clog2(BYTE_W + 2);
  localparam logic [BIT_W-1:0] RX_LAST_DATA = BIT_W'(BYTE_W - 1);
  localparam logic [BIT_W-1:0] TX_LAST_BIT  = BIT_W'(BYTE_W + 1);

  // spi sclk divider and bit index
  localparam int                   HALF_W       = $clog2(SPI_HALF_PERIOD);
  localparam logic [HALF_W-1:0]    HALF_LAST    = HALF_W'(SPI_HALF_PERIOD - 1);
  localparam int                   SPI_IDX_W    = $clog2(SPI_FRAME_W);
  localparam logic [SPI_IDX_W-1:0] SPI_LAST_IDX = SPI_IDX_W'(SPI_FRAME_W - 1);

  // slm reset stretch
  localparam int                HOLD_W    = $clog2(RESET_HOLD_CYCLES + 1);
  localparam logic [HOLD_W-1:0] HOLD_LOAD = HOLD_W'(RESET_HOLD_CYCLES);

  // reply queue pointers, depth is a power of two
  localparam int PTR_W = $clog2(REPLY_DEPTH);

  // uart receiver states
  localparam logic [1:0] RX_IDLE  = 2'd0;
  localparam logic [1:0] RX_START = 2'd1;
  localparam logic [1:0] RX_DATA  = 2'd2;
  localparam logic [1:0] RX_STOP  = 2'd3;

  typedef logic [BYTE_W-1:0] byte_t;

  // one spi write, raw for the shifter, split for the assembler
  typedef union packed {
    logic [SPI_FRAME_W-1:0] raw;
    struct packed {
      byte_t addr;
      byte_t data;
    } field;
  } spi_frame_u;

endpackage

// ==== design/slm_ctrl_top.sv ====
`timescale 1ns/1ns

module slm_ctrl_top (
  input  logic fpga_clk,
  input  logic reset_all_cmd_w,
  input  logic uart_rx_i,
  output logic uart_tx_o,
  output logic spi_cs_n_o,
  output logic spi_sclk_o,
  output logic spi_mosi_o,
  input  logic spi_miso_i,
  output logic slm_reset_n_o
);

  // uart rx to assembler
  logic                     rx_valid;
  slm_ctrl_pkg::byte_t      rx_byte;
  // assembler to spi master
  logic                     spi_start;
  slm_ctrl_pkg::spi_frame_u spi_frame;
  logic                     spi_busy;
  // spi reply into queue
  logic                     reply_valid;
  slm_ctrl_pkg::byte_t      reply_byte;
  // queue to uart tx
  logic                     tx_start;
  slm_ctrl_pkg::byte_t      tx_byte;
  logic                     tx_active;

  ////////////////////////////////////////////////////////////////////////////
  // host command path
  ////////////////////////////////////////////////////////////////////////////
  uart_rx u_uart_rx (
    .fpga_clk(fpga_clk), .reset_all_cmd_w(reset_all_cmd_w),
    .rx_serial_i(uart_rx_i), .rx_valid_o(rx_valid), .rx_byte_o(rx_byte)
  );

  spi_cmd_assembler u_spi_cmd_assembler (
    .fpga_clk(fpga_clk), .reset_all_cmd_w(reset_all_cmd_w),
    .rx_valid_i(rx_valid), .rx_byte_i(rx_byte), .spi_busy_i(spi_busy),
    .spi_start_o(spi_start), .spi_frame_o(spi_frame)
  );

  spi_master u_spi_master (
    .fpga_clk(fpga_clk), .reset_all_cmd_w(reset_all_cmd_w),
    .start_i(spi_start), .frame_i(spi_frame), .busy_o(spi_busy),
    .reply_valid_o(reply_valid), .reply_byte_o(reply_byte),
    .cs_n_o(spi_cs_n_o), .sclk_o(spi_sclk_o), .mosi_o(spi_mosi_o), .miso_i(spi_miso_i)
  );

  ////////////////////////////////////////////////////////////////////////////
  // reply path and slm reset
  ////////////////////////////////////////////////////////////////////////////
  uart_reply_queue u_uart_reply_queue (
    .fpga_clk(fpga_clk), .reset_all_cmd_w(reset_all_cmd_w),
    .wr_valid_i(reply_valid), .wr_byte_i(reply_byte), .tx_active_i(tx_active),
    .tx_start_o(tx_start), .tx_byte_o(tx_byte)
  );

  uart_tx u_uart_tx (
    .fpga_clk(fpga_clk), .reset_all_cmd_w(reset_all_cmd_w),
    .tx_start_i(tx_start), .tx_byte_i(tx_byte),
    .tx_serial_o(uart_tx_o), .tx_active_o(tx_active)
  );

  slm_reset_gen u_slm_reset_gen (
    .fpga_clk(fpga_clk), .reset_all_cmd_w(reset_all_cmd_w), .slm_reset_n_o(slm_reset_n_o)
  );

endmodule

// ==== design/slm_reset_gen.sv ====
`timescale 1ns/1ns

module slm_reset_gen (
  input  logic fpga_clk,
  input  logic reset_all_cmd_w,
  output logic slm_reset_n_o
);

  // cycles of hold left after board reset drops
  logic [slm_ctrl_pkg::HOLD_W-1:0] hold_cnt;

  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      // reload and hold slm in reset
      hold_cnt      <= slm_ctrl_pkg::HOLD_LOAD;
      slm_reset_n_o <= 1'b0;
    end else if (hold_cnt != '0) begin
      hold_cnt      <= hold_cnt - 1'b1;
      slm_reset_n_o <= 1'b0;
    end else begin
      // stretch expired, release
      slm_reset_n_o <= 1'b1;
    end
  end

endmodule

// ==== design/spi_cmd_assembler.sv ====
`timescale 1ns/1ns

module spi_cmd_assembler (
  input  logic                     fpga_clk,
  input  logic                     reset_all_cmd_w,
  input  logic                     rx_valid_i,
  input  slm_ctrl_pkg::byte_t      rx_byte_i,
  input  logic                     spi_busy_i,
  output logic                     spi_start_o,
  output slm_ctrl_pkg::spi_frame_u spi_frame_o
);

  // low on address byte, high on data byte
  logic data_phase;

  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      data_phase  <= 1'b0;
      spi_start_o <= 1'b0;
    end else begin
      spi_start_o <= 1'b0;
      if (rx_valid_i) begin
        // always back to address after a data byte
        data_phase <= !data_phase;
        // pair complete, launch unless master still busy
        if (data_phase && !spi_busy_i) spi_start_o <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // frame fields
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge fpga_clk) begin
    if (rx_valid_i) begin
      if (!data_phase) begin
        spi_frame_o.field.addr <= rx_byte_i;
      end else if (!spi_busy_i) begin
        // discarded byte leaves the last frame untouched
        spi_frame_o.field.data <= rx_byte_i;
      end
    end
  end

endmodule

// ==== design/spi_master.sv ====
`timescale 1ns/1ns

module spi_master (
  input  logic                     fpga_clk,
  input  logic                     reset_all_cmd_w,
  input  logic                     start_i,
  input  slm_ctrl_pkg::spi_frame_u frame_i,
  output logic                     busy_o,
  output logic                     reply_valid_o,
  output slm_ctrl_pkg::byte_t      reply_byte_o,
  output logic                     cs_n_o,
  output logic                     sclk_o,
  output logic                     mosi_o,
  input  logic                     miso_i
);

  // sclk half-period divider
  logic [slm_ctrl_pkg::HALF_W-1:0]    half_cnt;
  logic                               half_tick;
  // bits clocked so far
  logic [slm_ctrl_pkg::SPI_IDX_W-1:0] bit_cnt;
  // last falling edge done, waiting out the cs tail
  logic                               last_bit;
  // mosi leaves the top, miso enters the bottom
  slm_ctrl_pkg::spi_frame_u           shift_q;
  logic                               launch;

  assign half_tick = (half_cnt == slm_ctrl_pkg::HALF_LAST);
  assign launch    = start_i && !busy_o;

  ////////////////////////////////////////////////////////////////////////////
  // cs, sclk and mosi sequencing
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      busy_o        <= 1'b0;
      reply_valid_o <= 1'b0;
      cs_n_o        <= 1'b1;
      sclk_o        <= 1'b0;
      mosi_o        <= 1'b1;
      half_cnt      <= '0;
      bit_cnt       <= '0;
      last_bit      <= 1'b0;
    end else begin
      reply_valid_o <= 1'b0;
      if (!busy_o) begin
        if (start_i) begin
          // cs low with msb already on mosi
          busy_o   <= 1'b1;
          cs_n_o   <= 1'b0;
          mosi_o   <= frame_i.raw[slm_ctrl_pkg::SPI_FRAME_W-1];
          half_cnt <= '0;
          bit_cnt  <= '0;
          last_bit <= 1'b0;
        end
      end else if (!half_tick) begin
        half_cnt <= half_cnt + 1'b1;
      end else begin
        half_cnt <= '0;
        if (sclk_o) begin
          // falling edge, next bit onto mosi
          sclk_o   <= 1'b0;
          mosi_o   <= shift_q.raw[slm_ctrl_pkg::SPI_FRAME_W-1];
          bit_cnt  <= bit_cnt + 1'b1;
          last_bit <= (bit_cnt == slm_ctrl_pkg::SPI_LAST_IDX);
        end else if (last_bit) begin
          // half period after the final fall
          cs_n_o        <= 1'b1;
          busy_o        <= 1'b0;
          reply_valid_o <= 1'b1;
          mosi_o        <= 1'b1;
        end else begin
          sclk_o <= 1'b1;
        end
      end
    end
  end

  // shifter, miso captured as sclk rises
  always_ff @(posedge fpga_clk) begin
    if (launch) begin
      shift_q.raw <= frame_i.raw;
    end else if (busy_o && half_tick && !sclk_o && !last_bit) begin
      shift_q.raw <= {shift_q.raw[slm_ctrl_pkg::SPI_FRAME_W-2:0], miso_i};
    end
  end

  // last eight bits sampled, stable after cs rises
  assign reply_byte_o = shift_q.raw[slm_ctrl_pkg::BYTE_W-1:0];

endmodule

// ==== design/uart_reply_queue.sv ====
`timescale 1ns/1ns

module uart_reply_queue (
  input  logic                fpga_clk,
  input  logic                reset_all_cmd_w,
  input  logic                wr_valid_i,
  input  slm_ctrl_pkg::byte_t wr_byte_i,
  input  logic                tx_active_i,
  output logic                tx_start_o,
  output slm_ctrl_pkg::byte_t tx_byte_o
);

  slm_ctrl_pkg::byte_t            mem [slm_ctrl_pkg::REPLY_DEPTH];
  logic [slm_ctrl_pkg::PTR_W-1:0] wr_ptr;
  logic [slm_ctrl_pkg::PTR_W-1:0] rd_ptr;
  logic [slm_ctrl_pkg::PTR_W:0]   count;
  logic                           full;
  logic                           empty;
  logic                           wr_en;
  logic                           rd_en;

  // top count bit set only at depth
  assign full  = count[slm_ctrl_pkg::PTR_W];
  assign empty = (count == '0);
  // replies into a full queue are lost
  assign wr_en = wr_valid_i && !full;
  // hold off while tx busy, and in the launch cycle before active rises
  assign rd_en = !empty && !tx_active_i && !tx_start_o;

  ////////////////////////////////////////////////////////////////////////////
  // pointers, count and launch
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      tx_start_o <= 1'b0;
    end else begin
      // launch one cycle after the read
      tx_start_o <= rd_en;
      if (wr_en) wr_ptr <= wr_ptr + 1'b1;
      if (rd_en) rd_ptr <= rd_ptr + 1'b1;
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // storage and read data
  always_ff @(posedge fpga_clk) begin
    if (wr_en) mem[wr_ptr] <= wr_byte_i;
    if (rd_en) tx_byte_o <= mem[rd_ptr];
  end

endmodule

// ==== design/uart_rx.sv ====
`timescale 1ns/1ns

module uart_rx (
  input  logic                fpga_clk,
  input  logic                reset_all_cmd_w,
  input  logic                rx_serial_i,
  output logic                rx_valid_o,
  output slm_ctrl_pkg::byte_t rx_byte_o
);

  // two-flop synchronizer on the async line
  logic                            rx_meta;
  logic                            rx_sync;
  logic [1:0]                      state;
  logic [slm_ctrl_pkg::BAUD_W-1:0] baud_cnt;
  logic [slm_ctrl_pkg::BIT_W-1:0]  bit_cnt;
  slm_ctrl_pkg::byte_t             shift_q;

  // line idles high
  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= rx_serial_i;
      rx_sync <= rx_meta;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // frame fsm
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      state      <= slm_ctrl_pkg::RX_IDLE;
      baud_cnt   <= '0;
      bit_cnt    <= '0;
      rx_valid_o <= 1'b0;
    end else begin
      rx_valid_o <= 1'b0;
      case (state)
        slm_ctrl_pkg::RX_IDLE: begin
          baud_cnt <= '0;
          bit_cnt  <= '0;
          // falling edge of start bit
          if (!rx_sync) state <= slm_ctrl_pkg::RX_START;
        end
        slm_ctrl_pkg::RX_START: begin
          if (baud_cnt == slm_ctrl_pkg::BAUD_MID) begin
            baud_cnt <= '0;
            // still low at mid-bit, else a glitch
            state    <= rx_sync ? slm_ctrl_pkg::RX_IDLE : slm_ctrl_pkg::RX_DATA;
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        slm_ctrl_pkg::RX_DATA: begin
          if (baud_cnt == slm_ctrl_pkg::BAUD_LAST) begin
            baud_cnt <= '0;
            bit_cnt  <= bit_cnt + 1'b1;
            if (bit_cnt == slm_ctrl_pkg::RX_LAST_DATA) state <= slm_ctrl_pkg::RX_STOP;
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        default: begin
          // mid stop bit, pulse only on a valid stop
          if (baud_cnt == slm_ctrl_pkg::BAUD_LAST) begin
            state      <= slm_ctrl_pkg::RX_IDLE;
            rx_valid_o <= rx_sync;
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
      endcase
    end
  end

  // data bits, lsb first
  always_ff @(posedge fpga_clk) begin
    if (state == slm_ctrl_pkg::RX_DATA && baud_cnt == slm_ctrl_pkg::BAUD_LAST) begin
      shift_q <= {rx_sync, shift_q[slm_ctrl_pkg::BYTE_W-1:1]};
    end
  end

  // held stable until the next data phase
  assign rx_byte_o = shift_q;

endmodule

// ==== design/uart_tx.sv ====
`timescale 1ns/1ns

module uart_tx (
  input  logic                fpga_clk,
  input  logic                reset_all_cmd_w,
  input  logic                tx_start_i,
  input  slm_ctrl_pkg::byte_t tx_byte_i,
  output logic                tx_serial_o,
  output logic                tx_active_o
);

  logic [slm_ctrl_pkg::BAUD_W-1:0] baud_cnt;
  logic [slm_ctrl_pkg::BIT_W-1:0]  bit_cnt;
  // stop bit above the data, shifted out lsb first
  logic [slm_ctrl_pkg::BYTE_W:0]   shift_q;
  logic                            bit_end;

  assign bit_end = (baud_cnt == slm_ctrl_pkg::BAUD_LAST);

  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      tx_active_o <= 1'b0;
      tx_serial_o <= 1'b1;
      baud_cnt    <= '0;
      bit_cnt     <= '0;
    end else if (!tx_active_o) begin
      // start bit goes out on the next cycle
      if (tx_start_i) begin
        tx_active_o <= 1'b1;
        tx_serial_o <= 1'b0;
        baud_cnt    <= '0;
        bit_cnt     <= '0;
      end
    end else if (!bit_end) begin
      baud_cnt <= baud_cnt + 1'b1;
    end else begin
      baud_cnt <= '0;
      if (bit_cnt == slm_ctrl_pkg::TX_LAST_BIT) begin
        // stop bit done, back to idle high
        tx_active_o <= 1'b0;
        tx_serial_o <= 1'b1;
      end else begin
        tx_serial_o <= shift_q[0];
        bit_cnt     <= bit_cnt + 1'b1;
      end
    end
  end

  // payload shifter
  always_ff @(posedge fpga_clk) begin
    if (!tx_active_o && tx_start_i) begin
      shift_q <= {1'b1, tx_byte_i};
    end else if (tx_active_o && bit_end) begin
      shift_q <= {1'b1, shift_q[slm_ctrl_pkg::BYTE_W:1]};
    end
  end

endmodule

// ==== flist.f ====
design/slm_ctrl_pkg.sv
design/uart_rx.sv
design/uart_tx.sv
design/spi_cmd_assembler.sv
design/spi_master.sv
design/uart_reply_queue.sv
design/slm_reset_gen.sv
design/slm_ctrl_top.sv
testbench/tb_slm_ctrl.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_slm_ctrl -f flist.f -o sim_tb_slm_ctrl
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/sim_tb_slm_ctrl)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -q "Testbench passed"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1

// ==== testbench/tb_slm_ctrl.sv ====
`timescale 1ns/1ns

module tb_slm_ctrl;

  localparam int ENTRIES  = 8;
  localparam int FRAME_W  = slm_ctrl_pkg::SPI_FRAME_W;
  localparam int BIT_T    = slm_ctrl_pkg::CLKS_PER_BIT;
  // one uart character, start to stop
  localparam int BYTE_T   = 10 * slm_ctrl_pkg::CLKS_PER_BIT;
  localparam int WAIT_MAX = 60 * slm_ctrl_pkg::CLKS_PER_BIT;

  logic fpga_clk = 1'b0;
  logic reset_all_cmd_w;
  logic uart_rx_i;
  logic uart_tx_o;
  logic spi_cs_n_o;
  logic spi_sclk_o;
  logic spi_mosi_o;
  logic spi_miso_i = 1'b0;
  logic slm_reset_n_o;

  // stimulus table, address then data, plus the byte the slave returns
  slm_ctrl_pkg::byte_t tbl_addr [ENTRIES];
  slm_ctrl_pkg::byte_t tbl_data [ENTRIES];
  slm_ctrl_pkg::byte_t tbl_reply [ENTRIES];
  slm_ctrl_pkg::byte_t burst_got [ENTRIES];
  slm_ctrl_pkg::byte_t got;
  logic [31:0]         lfsr;
  logic [23:0]         rand_bits;

  // spi slave model state
  logic               sclk_q = 1'b0;
  logic               cs_q = 1'b1;
  int                 rise_cnt = 0;
  int                 fall_cnt = 0;
  int                 frame_cnt = 0;
  logic [FRAME_W-1:0] spi_word = '0;
  logic [FRAME_W-1:0] frames [2*ENTRIES];

  slm_ctrl_top uut (
    .fpga_clk(fpga_clk), .reset_all_cmd_w(reset_all_cmd_w),
    .uart_rx_i(uart_rx_i), .uart_tx_o(uart_tx_o),
    .spi_cs_n_o(spi_cs_n_o), .spi_sclk_o(spi_sclk_o), .spi_mosi_o(spi_mosi_o),
    .spi_miso_i(spi_miso_i), .slm_reset_n_o(slm_reset_n_o)
  );

  always #5 fpga_clk = ~fpga_clk;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      fail_run($sformatf("FAILED %s expected %0h actual %0h", name, expected, actual));
    end
  endtask

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic set_entry(input int i, input slm_ctrl_pkg::byte_t a,
                           input slm_ctrl_pkg::byte_t d, input slm_ctrl_pkg::byte_t r);
    tbl_addr[i]  = a;
    tbl_data[i]  = d;
    tbl_reply[i] = r;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // uart driver and monitor
  ////////////////////////////////////////////////////////////////////////////
  // 8n1, lsb first, starts on a falling clock edge
  task automatic send_byte(input slm_ctrl_pkg::byte_t b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      uart_rx_i = frame[i];
      repeat (BIT_T) @(negedge fpga_clk);
    end
  endtask

  task automatic receive_byte(output slm_ctrl_pkg::byte_t b);
    int waited;
    waited = 0;
    while (uart_tx_o !== 1'b0) begin
      if (waited == WAIT_MAX) fail_run("timed out waiting for a start bit on uart_tx_o");
      waited++;
      @(negedge fpga_clk);
    end
    // move to mid start bit
    repeat (BIT_T / 2) @(negedge fpga_clk);
    if (uart_tx_o !== 1'b0) fail_run("start bit on uart_tx_o ended before mid-bit");
    for (int i = 0; i < 8; i++) begin
      repeat (BIT_T) @(negedge fpga_clk);
      b[i] = uart_tx_o;
    end
    repeat (BIT_T) @(negedge fpga_clk);
    if (uart_tx_o !== 1'b1) fail_run("stop bit on uart_tx_o was not high");
  endtask

  task automatic wait_frames(input int n);
    int waited;
    waited = 0;
    while (frame_cnt < n) begin
      if (waited == WAIT_MAX) fail_run("timed out waiting for an spi frame to finish");
      waited++;
      @(negedge fpga_clk);
    end
  endtask

  // count edges with the slm still held, from the first edge after release
  task automatic check_reset_stretch();
    int low_cycles;
    low_cycles = 0;
    @(negedge fpga_clk);
    while (slm_reset_n_o !== 1'b1) begin
      if (low_cycles == 4 * slm_ctrl_pkg::RESET_HOLD_CYCLES) begin
        fail_run("slm_reset_n_o never released after board reset");
      end
      low_cycles++;
      @(negedge fpga_clk);
    end
    check_value("slm reset hold cycles", slm_ctrl_pkg::RESET_HOLD_CYCLES, low_cycles);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // spi slave model
  ////////////////////////////////////////////////////////////////////////////
  always @(negedge fpga_clk) begin
    sclk_q <= spi_sclk_o;
    cs_q   <= spi_cs_n_o;
    if (cs_q && !spi_cs_n_o) begin
      rise_cnt   <= 0;
      fall_cnt   <= 0;
      spi_miso_i <= 1'b0;
    end
    // mosi taken on sclk rise
    if (!spi_cs_n_o && !sclk_q && spi_sclk_o) begin
      spi_word <= {spi_word[FRAME_W-2:0], spi_mosi_o};
      rise_cnt <= rise_cnt + 1;
    end
    // reply msb first over the last eight bits
    if (!spi_cs_n_o && sclk_q && !spi_sclk_o) begin
      fall_cnt <= fall_cnt + 1;
      if (fall_cnt >= 7 && fall_cnt <= 14) begin
        spi_miso_i <= tbl_reply[frame_cnt % ENTRIES][14 - fall_cnt];
      end
    end
    if (!cs_q && spi_cs_n_o) begin
      check_value($sformatf("sclk rises in frame %0d", frame_cnt), FRAME_W, rise_cnt);
      if (frame_cnt < 2 * ENTRIES) frames[frame_cnt] <= spi_word;
      frame_cnt <= frame_cnt + 1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    reset_all_cmd_w = 1'b1;
    uart_rx_i       = 1'b1;
    set_entry(0, 8'hf8, 8'h00, 8'h5a);
    set_entry(1, 8'h09, 8'h32, 8'hc3);
    set_entry(2, 8'h89, 8'h00, 8'h7e);
    set_entry(3, 8'hbc, 8'ha5, 8'h81);
    // remaining entries, one lfsr step per bit
    lfsr = 32'hb655a013;
    for (int i = 4; i < ENTRIES; i++) begin
      for (int k = 0; k < 24; k++) begin
        lfsr      = lfsr_next(lfsr);
        rand_bits = {rand_bits[22:0], lfsr[0]};
      end
      set_entry(i, rand_bits[23:16], rand_bits[15:8], rand_bits[7:0]);
    end

    repeat (5) @(negedge fpga_clk);
    check_value("slm reset during reset", 0, 32'(slm_reset_n_o));
    check_value("cs idle after reset", 1, 32'(spi_cs_n_o));
    check_value("uart tx idle after reset", 1, 32'(uart_tx_o));
    check_value("sclk idle after reset", 0, 32'(spi_sclk_o));
    reset_all_cmd_w = 1'b0;
    check_reset_stretch();

    // one entry at a time, half pair first
    for (int i = 0; i < ENTRIES; i++) begin
      send_byte(tbl_addr[i]);
      for (int c = 0; c < BYTE_T; c++) begin
        check_value($sformatf("cs high after address %0d", i), 1, 32'(spi_cs_n_o));
        @(negedge fpga_clk);
      end
      send_byte(tbl_data[i]);
      receive_byte(got);
      wait_frames(i + 1);
      check_value($sformatf("frame count %0d", i), i + 1, frame_cnt);
      check_value($sformatf("spi word %0d", i), 32'({tbl_addr[i], tbl_data[i]}),
                  32'(frames[i]));
      check_value($sformatf("reply byte %0d", i), 32'(tbl_reply[i]), 32'(got));
    end

    // all entries back to back, replies collected alongside
    fork
      begin
        for (int i = 0; i < ENTRIES; i++) begin
          send_byte(tbl_addr[i]);
          send_byte(tbl_data[i]);
        end
      end
      begin
        for (int i = 0; i < ENTRIES; i++) begin
          receive_byte(burst_got[i]);
        end
      end
    join
    wait_frames(2 * ENTRIES);
    for (int i = 0; i < ENTRIES; i++) begin
      check_value($sformatf("burst spi word %0d", i), 32'({tbl_addr[i], tbl_data[i]}),
                  32'(frames[ENTRIES + i]));
      check_value($sformatf("burst reply %0d", i), 32'(tbl_reply[i]), 32'(burst_got[i]));
    end

    // nothing extra after the burst
    for (int c = 0; c < BYTE_T; c++) begin
      check_value("uart tx idle after burst", 1, 32'(uart_tx_o));
      @(negedge fpga_clk);
    end
    check_value("total frames", 2 * ENTRIES, frame_cnt);

    $display("Testbench passed");
    $finish;
  end

endmodule
